/* tb.f */
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_sequencer.sv
rtl/weight_rom.sv
rtl/mac_array.sv
rtl/requant_relu.sv
rtl/conv_layer.sv
verification/conv_layer_tb.sv

/* Bender.yml */
package:
  name: conv_layer

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/conv_pkg.sv
      - rtl/conv_sequencer.sv
      - rtl/weight_rom.sv
      - rtl/mac_array.sv
      - rtl/requant_relu.sv
      - rtl/conv_layer.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/conv_layer_tb.sv

/* verification/conv_layer_tb.sv */
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_layer_tb import conv_pkg::*; ();

	localparam int TAPS = `CONV_TAPS;
	localparam int WINDOWS = `CONV_WOUT * `CONV_WOUT;
	localparam int LATENCY = 4; // falling edges from the last tap drive to its sample.
	localparam int SAMPLE_TIMEOUT = 40;

	logic clk;
	logic rst;
	logic en;
	pixel_t ifm;
	logic ram_feedback;
	act_vec_t ofm;
	logic sample;
	logic finish;

	pixel_t win_pix [TAPS]; // stimulus of the current window.
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int sample_cnt = 0;
	logic finish_before; // finish one cycle ahead of the latest sample.

	conv_layer i_dut (
		.clk (clk),
		.rst (rst),
		.en (en),
		.ifm (ifm),
		.ram_feedback (ram_feedback),
		.ofm (ofm),
		.sample (sample),
		.finish (finish)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// expected ofm of win_pix after dot product, bias, relu, shift and clamp.
	function automatic act_vec_t expected_ofm();
		act_vec_t res;
		longint acc;
		longint shifted;
		for (int l = 0; l < `CONV_LANES; l++) begin
			acc = 0;
			for (int t = 0; t < TAPS; t++)
				acc += longint'(win_pix[t]) * longint'(kernel_weight(l, t));
			acc += longint'(lane_bias(l));
			shifted = acc >>> `CONV_FRAC_BITS;
			if (acc < 0)
				res[l] = '0;
			else if (shifted > 32767)
				res[l] = 16'h7fff;
			else
				res[l] = act_t'(shifted);
		end
		return res;
	endfunction

	// every step of the stimulus goes through here so samples are counted once.
	task automatic next_cycle();
		@(negedge clk);
		if (sample === 1'b1)
			sample_cnt++;
	endtask

	task automatic apply_reset();
		rst = 1'b0;
		en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		repeat (10) next_cycle();
		rst = 1'b1;
		sample_cnt = 0;
	endtask

	task automatic mark_test_start();
		test_errors = errors;
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("test %s: PASS", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL (%0d errors)", name, errors - test_errors);
		end
	endtask

	task automatic random_window();
		for (int t = 0; t < TAPS; t++)
			win_pix[t] = pixel_t'($urandom);
	endtask

	task automatic compare_ofm(input act_vec_t exp);
		for (int l = 0; l < `CONV_LANES; l++) begin
			if (ofm[l] !== exp[l]) begin
				$display("MISMATCH ofm lane %0d: got %h, expected %h", l, ofm[l], exp[l]);
				errors++;
			end
		end
	endtask

	// en drops while waiting. cycles counts falling edges up to the sample.
	task automatic wait_sample(output int cycles, output bit seen);
		cycles = 0;
		seen = 1'b0;
		finish_before = finish;
		while (!seen && cycles < SAMPLE_TIMEOUT) begin
			finish_before = finish;
			next_cycle();
			en = 1'b0;
			cycles++;
			if (sample === 1'b1)
				seen = 1'b1;
		end
		if (!seen) begin
			$display("timeout: no sample within %0d cycles of the last tap", SAMPLE_TIMEOUT);
			errors++;
		end
	endtask

	// drives win_pix with up to max_gap idle cycles before each tap.
	task automatic run_window(input int max_gap);
		act_vec_t exp;
		int gap;
		int cycles;
		bit seen;
		int cnt_before;
		exp = expected_ofm();
		cnt_before = sample_cnt;
		for (int t = 0; t < TAPS; t++) begin
			gap = $urandom_range(max_gap);
			repeat (gap) begin
				next_cycle();
				en = 1'b0;
			end
			next_cycle();
			en = 1'b1;
			ifm = win_pix[t];
		end
		wait_sample(cycles, seen);
		if (seen) begin
			if (cycles != LATENCY) begin
				$display("MISMATCH sample latency: got %h, expected %h", cycles, LATENCY);
				errors++;
			end
			compare_ofm(exp);
			if (sample_cnt != cnt_before + 1) begin
				$display("MISMATCH sample count: got %h, expected %h", sample_cnt,
					cnt_before + 1);
				errors++;
			end
		end
	endtask

	task automatic check_reset_state();
		mark_test_start();
		apply_reset();
		repeat (20) begin
			next_cycle();
			if (sample !== 1'b0) begin
				$display("MISMATCH sample: got %h, expected %h", sample, 1'b0);
				errors++;
			end
			if (finish !== 1'b0) begin
				$display("MISMATCH finish: got %h, expected %h", finish, 1'b0);
				errors++;
			end
			if (ofm !== '0) begin
				$display("MISMATCH ofm: got %h, expected %h", ofm, act_vec_t'(0));
				errors++;
			end
		end
		report_test("reset state");
	endtask

	task automatic run_continuous_window();
		mark_test_start();
		apply_reset();
		random_window();
		run_window(0);
		report_test("continuous window");
	endtask

	task automatic run_stalled_windows();
		mark_test_start();
		apply_reset();
		for (int w = 0; w < 4; w++) begin
			random_window();
			run_window(3);
		end
		repeat (10) next_cycle(); // no stray sample afterwards.
		if (sample_cnt != 4) begin
			$display("MISMATCH sample count: got %h, expected %h", sample_cnt, 4);
			errors++;
		end
		report_test("stalled windows");
	endtask

	// extreme pixels push lanes into relu or towards the clamp.
	task automatic check_relu_clamp();
		act_vec_t exp;
		int clamped;
		mark_test_start();
		apply_reset();
		clamped = 0;
		for (int k = 0; k < 4; k++) begin
			for (int t = 0; t < TAPS; t++) begin
				case (k)
					0: win_pix[t] = pixel_t'(-32768);
					1: win_pix[t] = pixel_t'(32767);
					2: win_pix[t] = (kernel_weight(3, t) >= 0) ? pixel_t'(32767) :
						pixel_t'(-32767);
					default: win_pix[t] = (kernel_weight(6, t) >= 0) ? pixel_t'(-32767) :
						pixel_t'(32767);
				endcase
			end
			exp = expected_ofm();
			for (int l = 0; l < `CONV_LANES; l++) begin
				if (exp[l] == 16'h0000 || exp[l] == 16'h7fff)
					clamped++;
			end
			run_window(0);
		end
		if (clamped == 0) begin
			$display("no lane was clamped to zero or to the maximum by these windows");
			errors++;
		end
		report_test("relu and saturation");
	endtask

	task automatic check_layer_end();
		logic exp_fin;
		mark_test_start();
		apply_reset();
		for (int w = 0; w < WINDOWS; w++) begin
			if (w == 9) begin
				next_cycle(); // early ram answer that must be ignored.
				en = 1'b0;
				ram_feedback = 1'b1;
				next_cycle();
				ram_feedback = 1'b0;
			end
			random_window();
			run_window(1);
			exp_fin = (w == WINDOWS - 1);
			if (finish !== exp_fin) begin
				$display("MISMATCH finish at window %0d: got %h, expected %h", w, finish,
					exp_fin);
				errors++;
			end
			if (w == WINDOWS - 1 && finish_before !== 1'b0) begin
				$display("MISMATCH finish before last sample: got %h, expected %h",
					finish_before, 1'b0);
				errors++;
			end
		end
		repeat (40) begin
			next_cycle();
			en = 1'b1;
			ifm = pixel_t'($urandom);
			if (finish !== 1'b1) begin
				$display("MISMATCH finish after layer end: got %h, expected %h", finish, 1'b1);
				errors++;
			end
		end
		next_cycle();
		en = 1'b0;
		repeat (LATENCY) next_cycle();
		if (sample_cnt != WINDOWS) begin
			$display("MISMATCH sample count: got %h, expected %h", sample_cnt, WINDOWS);
			errors++;
		end
		ram_feedback = 1'b1;
		next_cycle();
		ram_feedback = 1'b0;
		if (finish !== 1'b0) begin
			$display("MISMATCH finish after ram_feedback: got %h, expected %h", finish, 1'b0);
			errors++;
		end
		repeat (10) begin
			next_cycle();
			if (finish !== 1'b0) begin
				$display("MISMATCH finish: got %h, expected %h", finish, 1'b0);
				errors++;
			end
		end
		report_test("layer end and finish");
	endtask

	initial begin
		rst = 1'b0;
		en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		void'($urandom(32'hf378_6274));
		check_reset_state();
		run_continuous_window();
		run_stalled_windows();
		check_relu_clamp();
		check_layer_end();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* rtl/conv_layer.sv */
`timescale 1ns/1ps

module conv_layer import conv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic en,
	input pixel_t ifm,
	input logic ram_feedback,
	output act_vec_t ofm,
	output logic sample,
	output logic finish
);

	tap_ctrl_t ctrl;
	pixel_t pix;
	fetch_t fetch;
	sum_t sums;

	// stage 0, tap counting and layer end.
	conv_sequencer u_sequencer (
		.clk (clk),
		.rst (rst),
		.en (en),
		.ifm (ifm),
		.ram_feedback (ram_feedback),
		.ctrl (ctrl),
		.pix (pix),
		.finish (finish)
	);

	// stage 1.
	weight_rom u_weight_rom (
		.clk (clk),
		.rst (rst),
		.ctrl (ctrl),
		.pix (pix),
		.fetch (fetch)
	);

	// stage 2.
	mac_array u_mac_array (
		.clk (clk),
		.rst (rst),
		.fetch (fetch),
		.sums (sums)
	);

	// stage 3, sample lines up with finish on the last window.
	requant_relu u_requant_relu (
		.clk (clk),
		.rst (rst),
		.sums (sums),
		.ofm (ofm),
		.sample (sample)
	);

endmodule

/* rtl/requant_relu.sv */
`timescale 1ns/1ps
`include "conv_defines.svh"

module requant_relu import conv_pkg::*; (
	input logic clk,
	input logic rst,
	input sum_t sums,
	output act_vec_t ofm,
	output logic sample
);

	// largest positive activation.
	localparam acc_t ACT_MAX = acc_t'((1 << (`CONV_DATA_W - 1)) - 1);

	act_vec_t act_next;

	// bias, relu, shift and clamp for every lane.
	always_comb begin
		acc_t biased;
		acc_t shifted;
		for (int l = 0; l < `CONV_LANES; l++) begin
			biased = sums.acc[l] + acc_t'(lane_bias(l));
			shifted = biased >>> `CONV_FRAC_BITS;
			if (biased < 0)
				act_next[l] = '0; // relu.
			else if (shifted > ACT_MAX)
				act_next[l] = act_t'(ACT_MAX);
			else
				act_next[l] = act_t'(shifted);
		end
	end

	// ofm holds until the next finished window.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ofm <= '0;
			sample <= 1'b0;
		end else begin
			sample <= sums.valid; // one pulse per window.
			if (sums.valid)
				ofm <= act_next;
		end
	end

endmodule

/* rtl/mac_array.sv */
`timescale 1ns/1ps
`include "conv_defines.svh"

module mac_array import conv_pkg::*; (
	input logic clk,
	input logic rst,
	input fetch_t fetch,
	output sum_t sums
);

	acc_t acc_q [`CONV_LANES];
	acc_t acc_next [`CONV_LANES];
	acc_vec_t sum_q;
	logic sum_valid_q;

	for (genvar l = 0; l < `CONV_LANES; l++) begin : g_lane
		weight_t w;
		acc_t prod;

		assign w = fetch.weights[l];
		// evaluated at accumulator width, both operands sign extended.
		assign prod = fetch.pix * w;
		// a first tap restarts the window.
		assign acc_next[l] = fetch.first ? prod : acc_q[l] + prod;
	end

	// bubbles leave the accumulators untouched.
	always_ff @(posedge clk) begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			if (fetch.valid)
				acc_q[l] <= acc_next[l];
			if (fetch.valid && fetch.last)
				sum_q[l] <= acc_next[l]; // hand over the finished sum.
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			sum_valid_q <= 1'b0;
		else
			sum_valid_q <= fetch.valid && fetch.last;
	end

	assign sums = '{valid: sum_valid_q, acc: sum_q};

endmodule

/* rtl/weight_rom.sv */
`timescale 1ns/1ps
`include "conv_defines.svh"

module weight_rom import conv_pkg::*; (
	input logic clk,
	input logic rst,
	input tap_ctrl_t ctrl,
	input pixel_t pix,
	output fetch_t fetch
);

	// one row of lane weights for a given tap.
	function automatic weight_vec_t row_weights(input int tap);
		weight_vec_t row;
		for (int l = 0; l < `CONV_LANES; l++) begin
			row[l] = kernel_weight(l, tap);
		end
		return row;
	endfunction

	weight_vec_t rom_table [`CONV_TAPS]; // constant, fixed at elaboration.

	for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_row
		assign rom_table[t] = row_weights(t);
	end

	logic valid_q;
	logic first_q;
	logic last_q;
	pixel_t pix_q;
	weight_vec_t weights_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
		end else begin
			valid_q <= ctrl.valid;
			first_q <= ctrl.first;
			last_q <= ctrl.last;
		end
	end

	// registered read, the pixel takes the same cycle.
	always_ff @(posedge clk) begin
		weights_q <= rom_table[ctrl.addr];
		pix_q <= pix;
	end

	assign fetch = '{valid: valid_q, first: first_q, last: last_q,
		pix: pix_q, weights: weights_q};

endmodule

/* rtl/conv_sequencer.sv */
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_sequencer import conv_pkg::*; (
	input logic clk,
	input logic rst,
	input logic en,
	input pixel_t ifm,
	input logic ram_feedback,
	output tap_ctrl_t ctrl,
	output pixel_t pix,
	output logic finish
);

	localparam int WINDOWS = `CONV_WOUT * `CONV_WOUT;
	// layer_end plus these stages line finish up with the last sample.
	localparam int END_DELAY = 3;

	tap_addr_t tap_cnt;
	logic [$clog2(WINDOWS)-1:0] win_cnt;
	logic layer_end;
	logic [END_DELAY-1:0] end_pipe;
	logic fb_seen; // ram answered after layer end.

	logic accept;
	logic last_tap;
	logic last_win;

	assign accept = en && !layer_end; // en is ignored once the layer is done.
	assign last_tap = (tap_cnt == tap_addr_t'(`CONV_TAPS - 1));
	assign last_win = (win_cnt == WINDOWS - 1);

	// tap and window counters.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_cnt <= '0;
			win_cnt <= '0;
		end else if (accept) begin
			if (last_tap) begin
				tap_cnt <= '0;
				if (!last_win)
					win_cnt <= win_cnt + 1'b1;
			end else begin
				tap_cnt <= tap_cnt + 1'b1;
			end
		end
	end

	// outgoing tap with its own flags, a bubble when nothing is accepted.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ctrl <= '0;
		end else begin
			ctrl.valid <= accept;
			ctrl.first <= accept && (tap_cnt == '0);
			ctrl.last <= accept && last_tap;
			ctrl.addr <= tap_cnt;
		end
	end

	always_ff @(posedge clk) begin
		pix <= ifm; // payload, follows ctrl one for one.
	end

	// layer end latches on the final tap of the final window.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			layer_end <= 1'b0;
			end_pipe <= '0;
			fb_seen <= 1'b0;
		end else begin
			if (accept && last_tap && last_win)
				layer_end <= 1'b1;
			end_pipe <= {end_pipe[END_DELAY-2:0], layer_end};
			if (ram_feedback && layer_end)
				fb_seen <= 1'b1; // early feedback is not armed.
		end
	end

	// drops on the edge that sees the ram answer.
	assign finish = end_pipe[END_DELAY-1] && !fb_seen;

endmodule

/* rtl/conv_pkg.sv */
`include "conv_defines.svh"

package conv_pkg;

	// scalar datapath types.
	typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
	typedef logic signed [`CONV_DATA_W-1:0] weight_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;
	typedef logic signed [`CONV_BIAS_W-1:0] bias_t;
	typedef logic [`CONV_DATA_W-1:0] act_t; // relu output, never negative.
	typedef logic [$clog2(`CONV_TAPS)-1:0] tap_addr_t;

	// one entry per lane.
	typedef weight_t [`CONV_LANES-1:0] weight_vec_t;
	typedef acc_t [`CONV_LANES-1:0] acc_vec_t;
	typedef act_t [`CONV_LANES-1:0] act_vec_t;

	// sequencer to weight rom.
	typedef struct packed {
		logic valid;
		logic first; // first tap of a window.
		logic last; // last tap of a window.
		tap_addr_t addr;
	} tap_ctrl_t;

	// weight rom to mac array, pixel kept aligned with its weights.
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		pixel_t pix;
		weight_vec_t weights;
	} fetch_t;

	// mac array to requantisation, valid only on a finished window.
	typedef struct packed {
		logic valid;
		acc_vec_t acc;
	} sum_t;

	// fixed weight rule, small values in -8..8.
	function automatic weight_t kernel_weight(input int lane, input int tap);
		int w;
		w = ((lane * 7 + tap * 3) % 17) - 8;
		return weight_t'(w);
	endfunction

	// per-lane bias rule.
	function automatic bias_t lane_bias(input int lane);
		int b;
		b = lane * 256 - 512;
		return bias_t'(b);
	endfunction

endpackage

/* rtl/conv_defines.svh */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// parallel output channels, one MAC lane each.
`define CONV_LANES 8

// kernel side and input channels.
`define CONV_KERNEL_DIM 3
`define CONV_CHIN 4

// taps per output pixel, side squared times channels.
`define CONV_TAPS (`CONV_KERNEL_DIM * `CONV_KERNEL_DIM * `CONV_CHIN)

// output map side, the layer has side squared pixels.
`define CONV_WOUT 4

// requantisation shift.
`define CONV_FRAC_BITS 8

// datapath widths.
`define CONV_DATA_W 16
`define CONV_ACC_W 40
`define CONV_BIAS_W 32

`endif
